// ==== source/lsu_settings.svh ====
// load/store path settings
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// entries in each request/response queue
`define LSU_QUEUE_DEPTH 4

// 64-bit words in the data memory
`define LSU_RAM_WORDS 256

`define LSU_ADDR_BITS 32

`endif

// ==== source/lsu_pkg.sv ====
// load/store path types
`default_nettype none
`include "lsu_settings.svh"

package lsu_pkg;

  // access width of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } access_size_t;

  // one word-wide memory request
  typedef struct packed {
    logic                      write;
    logic [`LSU_ADDR_BITS-4:0] word_addr;  // byte address without bits 2:0
    logic [63:0]               data;       // already shifted into its lanes
    logic [7:0]                strb;
  } mem_req_t;

  // raw word read back from memory
  typedef logic [63:0] load_resp_t;

endpackage

`default_nettype wire

// ==== source/req_fifo.sv ====
// valid/ready FIFO
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module req_fifo import lsu_pkg::*; #(
  parameter type payload_t = load_resp_t,
  parameter int  DEPTH     = `LSU_QUEUE_DEPTH
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   in_valid_i,
  input  payload_t               in_data_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output payload_t               out_data_o,
  input  logic                   out_ready_i,
  output logic [$clog2(DEPTH):0] count_o
);

  localparam int PTR_BITS = $clog2(DEPTH);

  payload_t            mem_q [DEPTH];  // storage
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS:0]   count_q;
  logic                push;
  logic                pop;

  assign in_ready_o  = (count_q != DEPTH);  // low when full
  assign out_valid_o = (count_q != 0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at DEPTH
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  // a push into a full queue would overwrite the held head
  a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));
  // a pop from an empty queue would leave the pointers apart
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
    (count_q == 0) |-> (wr_ptr_q == rd_ptr_q));

endmodule

`default_nettype wire

// ==== source/load_store_unit.sv ====
// load/store unit
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module load_store_unit import lsu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      load_i,
  input  logic                      store_i,
  input  logic                      sext_i,
  input  logic [`LSU_ADDR_BITS-1:0] addr_i,
  input  logic [63:0]               wdata_i,
  input  access_size_t              size_i,
  input  logic                      req_ready_i,
  output logic                      req_valid_o,
  output mem_req_t                  req_data_o,
  input  logic                      resp_valid_i,
  output logic                      resp_ready_o,
  input  load_resp_t                resp_data_i,
  input  logic                      req_slots_low_i,
  output logic [63:0]               rdata_o,
  output logic                      done_o,
  output logic                      busy_o
);

  logic         req_valid_q;
  mem_req_t     req_data_q;
  logic         load_pend_q;  // load issued, result not back yet
  logic         resp_got_q;
  load_resp_t   resp_word_q;
  logic [2:0]   offset_q;
  access_size_t size_q;
  logic         sext_q;
  logic         done_q;
  logic [63:0]  rdata_q;

  logic [2:0]   offset;
  logic [7:0]   size_mask;
  logic         misaligned;
  logic [63:0]  shifted;
  logic [63:0]  extended;

  assign offset = addr_i[2:0];

  // byte lanes covered by the access, and alignment check
  always_comb begin
    case (size_i)
      SIZE_BYTE: begin
        size_mask  = 8'h01;
        misaligned = 1'b0;
      end
      SIZE_HALF: begin
        size_mask  = 8'h03;
        misaligned = offset[0];
      end
      SIZE_WORD: begin
        size_mask  = 8'h0f;
        misaligned = |offset[1:0];
      end
      default: begin
        size_mask  = 8'hff;
        misaligned = |offset;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      req_valid_q <= 1'b0;
      load_pend_q <= 1'b0;
      resp_got_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (req_valid_q && req_ready_i) begin
        req_valid_q <= 1'b0;
        done_q      <= req_data_q.write;  // posted store ends once queued
      end
      if (load_i || store_i) req_valid_q <= 1'b1;
      if (load_i) load_pend_q <= 1'b1;
      if (resp_valid_i && resp_ready_o) resp_got_q <= 1'b1;
      if (resp_got_q) begin
        resp_got_q  <= 1'b0;
        load_pend_q <= 1'b0;
        done_q      <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_i || store_i) begin
      req_data_q.write     <= store_i;
      req_data_q.word_addr <= addr_i[`LSU_ADDR_BITS-1:3];
      req_data_q.data      <= wdata_i << {offset, 3'b000};
      req_data_q.strb      <= size_mask << offset;
      offset_q             <= offset;
      size_q               <= size_i;
      sext_q               <= sext_i;
    end
    if (resp_valid_i && resp_ready_o) resp_word_q <= resp_data_i;
    if (resp_got_q) rdata_q <= extended;  // held until the next load
  end

  // move the accessed lanes down, then extend from the access width
  assign shifted = resp_word_q >> {offset_q, 3'b000};

  always_comb begin
    case (size_q)
      SIZE_BYTE: extended = {{56{sext_q & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: extended = {{48{sext_q & shifted[15]}}, shifted[15:0]};
      SIZE_WORD: extended = {{32{sext_q & shifted[31]}}, shifted[31:0]};
      default:   extended = shifted;
    endcase
  end

  assign req_valid_o  = req_valid_q;
  assign req_data_o   = req_data_q;
  assign resp_ready_o = load_pend_q && !resp_got_q;
  assign rdata_o      = rdata_q;
  assign done_o       = done_q;
  assign busy_o       = load_pend_q || req_slots_low_i;  // keeps stores off a full queue

  a_cmd_not_busy: assert property (@(posedge clk) disable iff (reset_i)
    (load_i || store_i) |-> !busy_o);
  a_one_cmd: assert property (@(posedge clk) disable iff (reset_i)
    !(load_i && store_i));
  a_aligned: assert property (@(posedge clk) disable iff (reset_i)
    (load_i || store_i) |-> !misaligned);

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
// byte-strobed data memory
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module data_ram import lsu_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_valid_i,
  input  mem_req_t   req_data_i,
  output logic       req_ready_o,
  output logic       resp_valid_o,
  output load_resp_t resp_data_o,
  input  logic       resp_ready_i
);

  localparam int IDX_BITS = $clog2(`LSU_RAM_WORDS);

  logic [63:0]         mem_q [`LSU_RAM_WORDS];
  logic [IDX_BITS-1:0] idx;
  logic                accept;
  logic                resp_valid_q;
  load_resp_t          resp_data_q;

  assign idx = req_data_i.word_addr[IDX_BITS-1:0];  // address bits 10:3

  // stall while the response queue is full
  assign req_ready_o = resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (accept && req_data_i.write) begin
      for (int b = 0; b < 8; b++) begin
        if (req_data_i.strb[b]) mem_q[idx][8*b +: 8] <= req_data_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !req_data_i.write) resp_data_q <= mem_q[idx];
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept && !req_data_i.write) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;  // taken by the response queue
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

  // strobes are built in the unit, so an empty one means lost lanes
  a_write_strb: assert property (@(posedge clk) disable iff (reset_i)
    (req_valid_i && req_data_i.write) |-> (req_data_i.strb != 8'h00));

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
// load/store subsystem top
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module mem_subsystem import lsu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      load_i,
  input  logic                      store_i,
  input  logic [`LSU_ADDR_BITS-1:0] addr_i,
  input  logic [63:0]               wdata_i,
  input  access_size_t              size_i,
  input  logic                      sext_i,
  output logic [63:0]               rdata_o,
  output logic                      done_o,
  output logic                      busy_o
);

  localparam int QDEPTH = `LSU_QUEUE_DEPTH;

  logic                    req_valid;
  logic                    req_ready;
  mem_req_t                req_data;
  logic                    ram_req_valid;
  logic                    ram_req_ready;
  mem_req_t                ram_req_data;
  logic                    ram_resp_valid;
  logic                    ram_resp_ready;
  load_resp_t              ram_resp_data;
  logic                    resp_valid;
  logic                    resp_ready;
  load_resp_t              resp_data;
  logic [$clog2(QDEPTH):0] req_count;
  logic                    req_slots_low;

  assign req_slots_low = (req_count >= QDEPTH - 1);  // one or no free entries

  load_store_unit u_lsu (
    .clk             (clk),
    .reset_i         (reset_i),
    .load_i          (load_i),
    .store_i         (store_i),
    .sext_i          (sext_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .size_i          (size_i),
    .req_ready_i     (req_ready),
    .req_valid_o     (req_valid),
    .req_data_o      (req_data),
    .resp_valid_i    (resp_valid),
    .resp_ready_o    (resp_ready),
    .resp_data_i     (resp_data),
    .req_slots_low_i (req_slots_low),
    .rdata_o         (rdata_o),
    .done_o          (done_o),
    .busy_o          (busy_o)
  );

  req_fifo #(.payload_t(mem_req_t), .DEPTH(QDEPTH)) u_req_fifo (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (req_valid),
    .in_data_i   (req_data),
    .in_ready_o  (req_ready),
    .out_valid_o (ram_req_valid),
    .out_data_o  (ram_req_data),
    .out_ready_i (ram_req_ready),
    .count_o     (req_count)
  );

  data_ram u_ram (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (ram_req_valid),
    .req_data_i   (ram_req_data),
    .req_ready_o  (ram_req_ready),
    .resp_valid_o (ram_resp_valid),
    .resp_data_o  (ram_resp_data),
    .resp_ready_i (ram_resp_ready)
  );

  req_fifo #(.payload_t(load_resp_t), .DEPTH(QDEPTH)) u_resp_fifo (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (ram_resp_valid),
    .in_data_i   (ram_resp_data),
    .in_ready_o  (ram_resp_ready),
    .out_valid_o (resp_valid),
    .out_data_o  (resp_data),
    .out_ready_i (resp_ready),
    .count_o     ()
  );

endmodule

`default_nettype wire

// ==== bench/mem_subsystem_tb.sv ====
// load/store subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module mem_subsystem_tb import lsu_pkg::*; ();

  localparam int NUM_OPS     = 2 + 256 + 28 + 31 + 9 + 600;
  localparam int CYCLE_LIMIT = 20 * NUM_OPS;

  logic                      clk;
  logic                      reset_i;
  logic                      load_i;
  logic                      store_i;
  logic [`LSU_ADDR_BITS-1:0] addr_i;
  logic [63:0]               wdata_i;
  access_size_t              size_i;
  logic                      sext_i;
  logic [63:0]               rdata_o;
  logic                      done_o;
  logic                      busy_o;

  logic [63:0] shadow [`LSU_RAM_WORDS];  // reference copy of the memory
  logic [63:0] exp_rdata;
  logic        load_open;                // load issued and not yet finished
  logic [31:0] lcg_state;
  int          errors;
  int          errors_at_start;
  int          tests_passed;
  int          tests_failed;
  int          cycle_count;

  mem_subsystem DUT (
    .clk     (clk),
    .reset_i (reset_i),
    .load_i  (load_i),
    .store_i (store_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .size_i  (size_i),
    .sext_i  (sext_i),
    .rdata_o (rdata_o),
    .done_o  (done_o),
    .busy_o  (busy_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  a_reset_done: assert property (@(posedge clk) ($past(reset_i) && !reset_i) |-> !done_o)
    else begin
      $display("Fail %0t done_o got %b expected 0", $time, $sampled(done_o));
      errors++;
    end
  a_reset_busy: assert property (@(posedge clk) ($past(reset_i) && !reset_i) |-> !busy_o)
    else begin
      $display("Fail %0t busy_o got %b expected 0", $time, $sampled(busy_o));
      errors++;
    end

  // a store's done comes two edges after its command was sampled
  a_store_done: assert property (@(posedge clk) disable iff (reset_i)
    $past(store_i, 2) |-> done_o)
    else begin
      $display("Fail %0t done_o got %b expected 1", $time, $sampled(done_o));
      errors++;
    end
  a_done_source: assert property (@(posedge clk) disable iff (reset_i)
    (done_o && !$past(store_i, 2)) |-> load_open)
    else begin
      $display("done_o pulsed at %0t with no store or load to finish", $time);
      errors++;
    end

  a_load_data: assert property (@(posedge clk) disable iff (reset_i)
    (done_o && load_open && !$past(store_i, 2)) |-> (rdata_o == exp_rdata))
    else begin
      $display("Fail %0t rdata_o got %h expected %h", $time, $sampled(rdata_o),
               $sampled(exp_rdata));
      errors++;
    end
  a_load_idle: assert property (@(posedge clk) disable iff (reset_i)
    (done_o && load_open && !$past(store_i, 2)) |-> !busy_o)
    else begin
      $display("Fail %0t busy_o got %b expected 0", $time, $sampled(busy_o));
      errors++;
    end

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // gather the accessed bytes, then fill the upper bytes with the sign
  function automatic logic [63:0] expect_load(input logic [31:0] addr, input logic [1:0] sz,
                                              input logic sx);
    logic [63:0] val;
    int          nbytes;
    nbytes = 1 << sz;
    val    = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < nbytes) val[8*i +: 8] = shadow[addr[10:3]][8*(addr[2:0] + i) +: 8];
      else if (sx && val[8*nbytes-1]) val[8*i +: 8] = 8'hff;
    end
    return val;
  endfunction

  task automatic write_shadow(input logic [31:0] addr, input logic [1:0] sz,
                              input logic [63:0] data);
    for (int i = 0; i < (1 << sz); i++) begin
      shadow[addr[10:3]][8*(addr[2:0] + i) +: 8] = data[8*i +: 8];
    end
  endtask

  task automatic issue(input logic is_load, input logic [31:0] addr, input logic [1:0] sz,
                       input logic sx, input logic [63:0] data);
    while (busy_o) begin
      @(posedge clk);
      #1;
    end
    addr_i  = addr;
    size_i  = access_size_t'(sz);
    sext_i  = sx;
    wdata_i = data;
    if (is_load) begin
      exp_rdata = expect_load(addr, sz, sx);
      load_open = 1'b1;
      load_i    = 1'b1;
    end else begin
      write_shadow(addr, sz, data);
      store_i = 1'b1;
    end
    @(posedge clk);
    #1;
    load_i  = 1'b0;
    store_i = 1'b0;
    if (is_load) begin
      while (!(done_o && !busy_o)) begin  // a store's done still shows busy
        @(posedge clk);
        #1;
      end
      @(posedge clk);
      #1;
      load_open = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    repeat (4) @(posedge clk);
    #1;
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped at the cycle limit of %0d before all tests finished", CYCLE_LIMIT);
    $display("Verification failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    reset_i = 1'b1;
    load_i = 1'b0;
    store_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    size_i = SIZE_BYTE;
    sext_i = 1'b0;
    exp_rdata = '0;
    load_open = 1'b0;
    lcg_state = 32'h595e;
    errors = 0;
    errors_at_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    #1;
    reset_i = 1'b0;

    issue(1'b0, 32'h40, 2'd3, 1'b0, 64'h0123_4567_89ab_cdef);
    issue(1'b1, 32'h40, 2'd3, 1'b0, '0);
    end_test("reset and double store/load");

    for (int w = 0; w < `LSU_RAM_WORDS; w++) begin
      a = w << 3;
      issue(1'b0, a, 2'd3, 1'b0, {~a * 32'h9e3779b1, a * 32'h85ebca6b});  // whole-address fill
    end

    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(1'b0, 32'h100 + off, sz[1:0], 1'b0, {next_rand(), next_rand()});
        issue(1'b1, 32'h100, 2'd3, 1'b0, '0);
      end
    end
    end_test("partial store merge");

    issue(1'b0, 32'h180, 2'd3, 1'b0, 64'hf07f_8001_7fff_ff80);  // mixed sign bytes
    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        issue(1'b1, 32'h180 + off, sz[1:0], 1'b0, '0);
        issue(1'b1, 32'h180 + off, sz[1:0], 1'b1, '0);
      end
    end
    end_test("load extension");

    for (int k = 0; k < 8; k++) begin
      issue(1'b0, 32'h200, 2'd3, 1'b0, {next_rand(), 32'h1000 + k});
    end
    issue(1'b1, 32'h200, 2'd3, 1'b0, '0);
    end_test("back-to-back store order");

    for (int n = 0; n < 600; n++) begin
      r = next_rand();
      a = (next_rand() & 32'h7ff) & ~((32'd1 << r[2:1]) - 32'd1);  // aligned to size
      issue(r[0], a, r[2:1], r[3], {next_rand(), next_rand()});
    end
    end_test("random mix");

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed,
             errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/lsu_pkg.sv
source/req_fifo.sv
source/load_store_unit.sv
source/data_ram.sv
source/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// ==== Makefile ====
TOP = mem_subsystem_tb

all: run

obj_dir/V$(TOP): compile.f source/*.sv source/*.svh bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
